//--- hw/fft16_pkg.sv
`default_nettype none

package fft16_pkg;

  localparam int n_points = 16;
  localparam int radix = 4;
  localparam int in_credits = 16;            // Equal to the loader depth
  localparam int sample_width = 16;
  localparam int tw_frac_bits = 14;          // Twiddles are Q1.14

  localparam int bin_bits = $clog2(n_points);
  localparam int in_credit_bits = $clog2(in_credits + 1);
  localparam int out_credit_bits = 16;

  // Two guard bits hold a four-term sum before the divide by 4
  localparam int acc_width = sample_width + 2;

  typedef struct packed {
    logic signed [sample_width-1:0] re;
    logic signed [sample_width-1:0] im;
  } sample_t;

  // Element 0 sits in the low bits
  typedef sample_t [radix-1:0] column_t;

  typedef struct packed {
    logic       valid;
    logic [1:0] idx;                         // Column index in stage 1, row index in stage 2
    logic       inverse;
  } stage_tag_t;

endpackage

`default_nettype wire

//--- hw/sample_loader.sv
`timescale 1ns/1ps
`default_nettype none

module sample_loader (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire fft16_pkg::sample_t    in_sample,
  input  wire                   in_valid,
  input  wire                   in_inverse,
  input  wire fft16_pkg::stage_tag_t rd_tag,
  output fft16_pkg::column_t    rd_col,
  output logic                  frame_ready,
  output logic                  frame_inverse,
  output logic                  in_credit
);

  fft16_pkg::sample_t mem [fft16_pkg::n_points];

  logic [fft16_pkg::bin_bits-1:0]       wr_ptr;
  logic [fft16_pkg::in_credit_bits-1:0] pending;
  logic [fft16_pkg::in_credit_bits-1:0] pending_add;
  logic                                 pending_take;

  // Natural order input lands at n = 4*n1 + n2
  always_ff @(posedge clk) begin
    if (in_valid) mem[wr_ptr] <= in_sample;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      frame_ready   <= 1'b0;
      frame_inverse <= 1'b0;
    end else begin
      if (in_valid) wr_ptr <= wr_ptr + 1'b1;
      if (in_valid && wr_ptr == '0) frame_inverse <= in_inverse;
      if (in_valid && wr_ptr == fft16_pkg::n_points - 1) begin
        frame_ready <= 1'b1;
      end else if (rd_tag.valid) begin
        frame_ready <= 1'b0;               // Stage 1 has taken the frame
      end
    end
  end

  // Column n2 gathers every fourth sample
  always_comb begin
    for (int n1 = 0; n1 < fft16_pkg::radix; n1++) begin
      rd_col[n1] = mem[fft16_pkg::radix * n1 + rd_tag.idx];
    end
  end

  // A column read frees four slots, handed back one credit per cycle
  assign pending_add  = rd_tag.valid ? fft16_pkg::in_credit_bits'(fft16_pkg::radix) : '0;
  assign pending_take = (pending != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending   <= '0;
      in_credit <= 1'b0;
    end else begin
      pending   <= pending + pending_add - {{(fft16_pkg::in_credit_bits-1){1'b0}}, pending_take};
      in_credit <= pending_take;
    end
  end

endmodule

`default_nettype wire

//--- hw/radix4_dft.sv
`timescale 1ns/1ps
`default_nettype none

module radix4_dft (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire fft16_pkg::column_t    in_col,
  input  wire fft16_pkg::stage_tag_t in_tag,
  output fft16_pkg::column_t    out_col,
  output fft16_pkg::stage_tag_t out_tag
);

  logic signed [fft16_pkg::acc_width-1:0] a_re, a_im, b_re, b_im;
  logic signed [fft16_pkg::acc_width-1:0] c_re, c_im, d_re, d_im;
  logic signed [fft16_pkg::acc_width-1:0] y_re [fft16_pkg::radix];
  logic signed [fft16_pkg::acc_width-1:0] y_im [fft16_pkg::radix];

  always_comb begin
    a_re = in_col[0].re + in_col[2].re;
    a_im = in_col[0].im + in_col[2].im;
    b_re = in_col[0].re - in_col[2].re;
    b_im = in_col[0].im - in_col[2].im;
    c_re = in_col[1].re + in_col[3].re;
    c_im = in_col[1].im + in_col[3].im;
    d_re = in_col[1].re - in_col[3].re;
    d_im = in_col[1].im - in_col[3].im;

    y_re[0] = a_re + c_re;
    y_im[0] = a_im + c_im;
    y_re[2] = a_re - c_re;
    y_im[2] = a_im - c_im;

    if (in_tag.inverse) begin
      // Bin 1 takes b + j*d
      y_re[1] = b_re - d_im;
      y_im[1] = b_im + d_re;
      y_re[3] = b_re + d_im;
      y_im[3] = b_im - d_re;
    end else begin
      y_re[1] = b_re + d_im;               // b - j*d
      y_im[1] = b_im - d_re;
      y_re[3] = b_re - d_im;
      y_im[3] = b_im + d_re;
    end
  end

  // Dropping the two low bits is the arithmetic shift by 2
  always_ff @(posedge clk) begin
    for (int k = 0; k < fft16_pkg::radix; k++) begin
      out_col[k].re <= y_re[k][fft16_pkg::acc_width-1:2];
      out_col[k].im <= y_im[k][fft16_pkg::acc_width-1:2];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) out_tag <= '0;
    else        out_tag <= in_tag;
  end

endmodule

`default_nettype wire

//--- hw/twiddle_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_rotator (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire fft16_pkg::column_t    in_col,
  input  wire fft16_pkg::stage_tag_t in_tag,
  output fft16_pkg::column_t    out_col,
  output fft16_pkg::stage_tag_t out_tag
);

  fft16_pkg::sample_t w [fft16_pkg::radix];
  logic signed [2*fft16_pkg::sample_width:0] prod_re [fft16_pkg::radix];
  logic signed [2*fft16_pkg::sample_width:0] prod_im [fft16_pkg::radix];

  // W16^m = cos(2*pi*m/16) - j*sin(2*pi*m/16) in Q1.14
  function automatic fft16_pkg::sample_t twiddle(input logic [3:0] m);
    fft16_pkg::sample_t t;
    case (m)
      4'd1:    t = '{re:  16'sd15137, im: -16'sd6270};
      4'd2:    t = '{re:  16'sd11585, im: -16'sd11585};
      4'd3:    t = '{re:  16'sd6270,  im: -16'sd15137};
      4'd4:    t = '{re:  16'sd0,     im: -16'sd16384};
      4'd5:    t = '{re: -16'sd6270,  im: -16'sd15137};
      4'd6:    t = '{re: -16'sd11585, im: -16'sd11585};
      4'd7:    t = '{re: -16'sd15137, im: -16'sd6270};
      4'd8:    t = '{re: -16'sd16384, im:  16'sd0};
      4'd9:    t = '{re: -16'sd15137, im:  16'sd6270};
      default: t = '{re:  16'sd16384, im:  16'sd0};   // Unity, rounds back exactly
    endcase
    return t;
  endfunction

  always_comb begin
    for (int k1 = 0; k1 < fft16_pkg::radix; k1++) begin
      w[k1] = twiddle(4'(in_tag.idx * k1));
      if (in_tag.inverse) w[k1].im = -w[k1].im;
      prod_re[k1] = in_col[k1].re * w[k1].re - in_col[k1].im * w[k1].im
                    + (1 <<< (fft16_pkg::tw_frac_bits - 1));
      prod_im[k1] = in_col[k1].re * w[k1].im + in_col[k1].im * w[k1].re
                    + (1 <<< (fft16_pkg::tw_frac_bits - 1));
    end
  end

  always_ff @(posedge clk) begin
    for (int k1 = 0; k1 < fft16_pkg::radix; k1++) begin
      out_col[k1].re <= prod_re[k1][fft16_pkg::tw_frac_bits +: fft16_pkg::sample_width];
      out_col[k1].im <= prod_im[k1][fft16_pkg::tw_frac_bits +: fft16_pkg::sample_width];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) out_tag <= '0;
    else        out_tag <= in_tag;
  end

endmodule

`default_nettype wire

//--- hw/corner_turn.sv
`timescale 1ns/1ps
`default_nettype none

module corner_turn (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire fft16_pkg::column_t    wr_col,
  input  wire fft16_pkg::stage_tag_t wr_tag,
  input  wire fft16_pkg::stage_tag_t rd_tag,
  output fft16_pkg::column_t    rd_row,
  output logic                  full,
  output logic                  empty
);

  fft16_pkg::column_t mem [fft16_pkg::radix];

  logic [2:0] wr_cnt;
  logic [1:0] rd_cnt;

  always_ff @(posedge clk) begin
    if (wr_tag.valid) mem[wr_tag.idx] <= wr_col;
  end

  // Row k1 takes element k1 out of every stored column
  always_comb begin
    for (int n2 = 0; n2 < fft16_pkg::radix; n2++) begin
      rd_row[n2] = mem[n2][rd_tag.idx];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
      rd_cnt <= '0;
    end else if (rd_tag.valid && rd_cnt == 2'(fft16_pkg::radix - 1)) begin
      wr_cnt <= '0;                        // Fourth row is out
      rd_cnt <= '0;
    end else begin
      if (wr_tag.valid) wr_cnt <= wr_cnt + 3'd1;
      if (rd_tag.valid) rd_cnt <= rd_cnt + 2'd1;
    end
  end

  assign full  = (wr_cnt == 3'(fft16_pkg::radix));
  assign empty = (wr_cnt == 3'd0);

endmodule

`default_nettype wire

//--- hw/sample_unloader.sv
`timescale 1ns/1ps
`default_nettype none

module sample_unloader (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire fft16_pkg::column_t    wr_row,
  input  wire fft16_pkg::stage_tag_t wr_tag,
  input  wire                   send,
  output fft16_pkg::sample_t    out_sample,
  output logic                  out_valid,
  output logic                  out_last,
  output logic                  full
);

  fft16_pkg::sample_t mem [fft16_pkg::n_points];

  logic [2:0]                     wr_cnt;
  logic [fft16_pkg::bin_bits-1:0] rd_ptr;

  // Element k2 of row k1 is bin k1 + 4*k2
  always_ff @(posedge clk) begin
    if (wr_tag.valid) begin
      for (int k2 = 0; k2 < fft16_pkg::radix; k2++) begin
        mem[fft16_pkg::radix * k2 + wr_tag.idx] <= wr_row[k2];
      end
    end
  end

  assign full       = (wr_cnt == 3'(fft16_pkg::radix));
  assign out_valid  = send && full;
  assign out_last   = out_valid && (rd_ptr == fft16_pkg::bin_bits'(fft16_pkg::n_points - 1));
  assign out_sample = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_tag.valid) wr_cnt <= wr_cnt + 3'd1;
      if (out_valid) begin
        rd_ptr <= rd_ptr + 1'b1;           // Wraps to bin 0 after bin 15
        if (out_last) wr_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/fft16_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_sequencer (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   frame_ready,
  input  wire                   frame_inverse,
  input  wire                   ct_full,
  input  wire                   ct_empty,
  input  wire                   unl_full,
  input  wire                   out_credit,
  output fft16_pkg::stage_tag_t s1_tag,
  output fft16_pkg::stage_tag_t s2_tag,
  output logic                  send
);

  logic                                  ct_inverse;
  logic [fft16_pkg::out_credit_bits-1:0] out_credits;

  // Stage 1 walks columns 0 to 3 once a frame is loaded and the corner turn is free
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_tag <= '0;
    end else if (s1_tag.valid) begin
      if (s1_tag.idx == 2'(fft16_pkg::radix - 1)) s1_tag.valid <= 1'b0;
      s1_tag.idx <= s1_tag.idx + 2'd1;
    end else if (frame_ready && ct_empty) begin
      s1_tag <= '{valid: 1'b1, idx: 2'd0, inverse: frame_inverse};
    end
  end

  // The corner turn holds one frame, so one direction bit follows it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)            ct_inverse <= 1'b0;
    else if (s1_tag.valid) ct_inverse <= s1_tag.inverse;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_tag <= '0;
    end else if (s2_tag.valid) begin
      if (s2_tag.idx == 2'(fft16_pkg::radix - 1)) s2_tag.valid <= 1'b0;
      s2_tag.idx <= s2_tag.idx + 2'd1;
    end else if (ct_full && !unl_full) begin
      s2_tag <= '{valid: 1'b1, idx: 2'd0, inverse: ct_inverse};
    end
  end

  assign send = (out_credits != '0) && unl_full;

  // Grants from the sink add up, each sent bin spends one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_credits <= '0;
    end else begin
      case ({out_credit, send})
        2'b10:   out_credits <= out_credits + 1'b1;
        2'b01:   out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/fft16_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire fft16_pkg::sample_t in_sample,
  input  wire                     in_valid,
  input  wire                     in_inverse,
  output wire                     in_credit,
  output wire fft16_pkg::sample_t out_sample,
  output wire                     out_valid,
  output wire                     out_last,
  input  wire                     out_credit
);

  wire fft16_pkg::stage_tag_t s1_tag;
  wire fft16_pkg::stage_tag_t s2_tag;
  wire fft16_pkg::column_t    loader_col;
  wire fft16_pkg::column_t    dft1_col;
  wire fft16_pkg::stage_tag_t dft1_tag;
  wire fft16_pkg::column_t    twiddle_col;
  wire fft16_pkg::stage_tag_t twiddle_tag;
  wire fft16_pkg::column_t    ct_row;
  wire fft16_pkg::column_t    dft2_col;
  wire fft16_pkg::stage_tag_t dft2_tag;
  wire                        frame_ready;
  wire                        frame_inverse;
  wire                        ct_full;
  wire                        ct_empty;
  wire                        unl_full;
  wire                        send;

  sample_loader loader_unit (
    .clk(clk),
    .rst_n(rst_n),
    .in_sample(in_sample),
    .in_valid(in_valid),
    .in_inverse(in_inverse),
    .rd_tag(s1_tag),
    .rd_col(loader_col),
    .frame_ready(frame_ready),
    .frame_inverse(frame_inverse),
    .in_credit(in_credit)
  );

  radix4_dft stage1_dft (
    .clk(clk),
    .rst_n(rst_n),
    .in_col(loader_col),
    .in_tag(s1_tag),
    .out_col(dft1_col),
    .out_tag(dft1_tag)
  );

  twiddle_rotator interdim_mult (
    .clk(clk),
    .rst_n(rst_n),
    .in_col(dft1_col),
    .in_tag(dft1_tag),
    .out_col(twiddle_col),
    .out_tag(twiddle_tag)
  );

  corner_turn ct_unit (
    .clk(clk),
    .rst_n(rst_n),
    .wr_col(twiddle_col),
    .wr_tag(twiddle_tag),
    .rd_tag(s2_tag),
    .rd_row(ct_row),
    .full(ct_full),
    .empty(ct_empty)
  );

  radix4_dft stage2_dft (
    .clk(clk),
    .rst_n(rst_n),
    .in_col(ct_row),
    .in_tag(s2_tag),
    .out_col(dft2_col),
    .out_tag(dft2_tag)
  );

  sample_unloader output_block (
    .clk(clk),
    .rst_n(rst_n),
    .wr_row(dft2_col),
    .wr_tag(dft2_tag),
    .send(send),
    .out_sample(out_sample),
    .out_valid(out_valid),
    .out_last(out_last),
    .full(unl_full)
  );

  fft16_sequencer master_ctrl (
    .clk(clk),
    .rst_n(rst_n),
    .frame_ready(frame_ready),
    .frame_inverse(frame_inverse),
    .ct_full(ct_full),
    .ct_empty(ct_empty),
    .unl_full(unl_full),
    .out_credit(out_credit),
    .s1_tag(s1_tag),
    .s2_tag(s2_tag),
    .send(send)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                // 40 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/fft16_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_properties (
  input wire                                    clk,
  input wire                                    rst_n,
  input wire                                    out_valid,
  input wire                                    out_last,
  input wire                                    out_credit,
  input wire                                    in_valid,
  input wire                                    in_credit,
  input wire [fft16_pkg::out_credit_bits-1:0]   out_credits
);

  // Samples taken by the loader and not yet credited back
  logic [5:0] outstanding;
  logic [fft16_pkg::out_credit_bits-1:0] granted;   // Sink grants not yet spent
  logic [fft16_pkg::bin_bits-1:0] beat;              // Bin of the next output

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= '0;
      granted     <= '0;
      beat        <= '0;
    end else begin
      outstanding <= outstanding + {5'd0, in_valid} - {5'd0, in_credit};
      granted     <= granted + fft16_pkg::out_credit_bits'(out_credit)
                     - fft16_pkg::out_credit_bits'(out_valid);
      beat        <= beat + fft16_pkg::bin_bits'(out_valid);
    end
  end

  send_needs_credit: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> (granted != '0)
  ) else $error("out_valid raised while no output credit was open");

  credit_count_tracks: assert property (
    @(posedge clk) disable iff (!rst_n) out_credits == granted
  ) else $error("Internal output credit count differs from the open sink grants");

  last_on_bin_15: assert property (
    @(posedge clk) disable iff (!rst_n) (out_valid || out_last) |->
      (out_last == (out_valid && beat == fft16_pkg::bin_bits'(fft16_pkg::n_points - 1)))
  ) else $error("out_last does not mark the 16th output of a frame");

  input_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n) outstanding <= 6'(fft16_pkg::in_credits)
  ) else $error("More than 16 input credits outstanding");

endmodule

bind fft16_top fft16_properties props (
  .clk(clk),
  .rst_n(rst_n),
  .out_valid(out_valid),
  .out_last(out_last),
  .out_credit(out_credit),
  .in_valid(in_valid),
  .in_credit(in_credit),
  .out_credits(master_ctrl.out_credits)
);

`default_nettype wire

//--- dv/fft16_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft16_tb;

  typedef enum int {pat_impulse, pat_dc, pat_tone, pat_alt} pattern_e;

  typedef struct {
    string    name;
    pattern_e pattern;
    int       amp;
    bit       inverse;
    int       exp_bin;                     // A negative bin puts the value in every bin
    int       exp_val;
  } frame_row_t;

  typedef struct packed {
    logic               inverse;
    fft16_pkg::sample_t sample;
  } stim_t;

  wire                     clk;
  wire                     rst_n;
  fft16_pkg::sample_t      in_sample = '0;
  logic                    in_valid = 1'b0;
  logic                    in_inverse = 1'b0;
  logic                    out_credit = 1'b0;
  wire                     in_credit;
  wire fft16_pkg::sample_t out_sample;
  wire                     out_valid;
  wire                     out_last;

  frame_row_t         frame_table[$];
  stim_t              stim_q[$];
  fft16_pkg::sample_t out_q[$];
  bit                 last_q[$];
  int                 src_credits = 0;
  int                 sent_count = 0;
  int                 returned_count = 0;
  int                 sink_outstanding = 0;
  int                 error_count = 0;
  int                 check_count = 0;
  bit                 random_grants = 1'b0;
  integer             seed = 32'hd9638dcd;
  bit                 ok;

  tb_clock_gen clock_unit (.clk(clk), .rst_n(rst_n));

  fft16_top i_fft16_top (
    .clk(clk),
    .rst_n(rst_n),
    .in_sample(in_sample),
    .in_valid(in_valid),
    .in_inverse(in_inverse),
    .in_credit(in_credit),
    .out_sample(out_sample),
    .out_valid(out_valid),
    .out_last(out_last),
    .out_credit(out_credit)
  );

  function automatic void add_row(input string name, input pattern_e pattern, input int amp,
                                  input bit inverse, input int exp_bin, input int exp_val);
    frame_row_t r;
    r.name    = name;
    r.pattern = pattern;
    r.amp     = amp;
    r.inverse = inverse;
    r.exp_bin = exp_bin;
    r.exp_val = exp_val;
    frame_table.push_back(r);
  endfunction

  function automatic fft16_pkg::sample_t pattern_sample(input pattern_e pattern, input int amp,
                                                        input int n);
    fft16_pkg::sample_t s;
    s = '0;
    case (pattern)
      pat_impulse: if (n == 0) s.re = 16'(amp);
      pat_dc:      s.re = 16'(amp);
      pat_tone: begin
        case (n % 4)                       // amp * j^n
          0:       s.re = 16'(amp);
          1:       s.im = 16'(amp);
          2:       s.re = 16'(-amp);
          default: s.im = 16'(-amp);
        endcase
      end
      default:     s.re = (n % 2 == 0) ? 16'(amp) : 16'(-amp);
    endcase
    return s;
  endfunction

  function automatic int expected_re(input frame_row_t row, input int bin);
    return (row.exp_bin < 0 || row.exp_bin == bin) ? row.exp_val : 0;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
      error_count++;
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic load_frames();
    stim_t s;
    foreach (frame_table[f]) begin
      for (int n = 0; n < fft16_pkg::n_points; n++) begin
        s.inverse = frame_table[f].inverse;
        s.sample  = pattern_sample(frame_table[f].pattern, frame_table[f].amp, n);
        stim_q.push_back(s);
      end
    end
  endtask

  task automatic wait_reset(output bit done);
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    done = rst_n;
    if (!done) begin
      error_count++;
      $display("Timeout: reset was never released");
    end
  endtask

  task automatic wait_outputs(input int count, output bit done);
    int cycles;
    cycles = 0;
    while (out_q.size() < count && cycles < 8000) begin
      @(posedge clk);
      cycles++;
    end
    done = (out_q.size() >= count);
    if (!done) begin
      error_count++;
      $display("Timeout: only %0d of %0d output samples arrived", out_q.size(), count);
    end
  endtask

  task automatic wait_credits(output bit done);
    int cycles;
    cycles = 0;
    while (src_credits != fft16_pkg::in_credits && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    done = (src_credits == fft16_pkg::in_credits);
    if (!done) begin
      error_count++;
      $display("Timeout: the source got only %0d input credits back", src_credits);
    end
  endtask

  task automatic check_outputs(input int pass);
    string name;
    int    idx;
    for (int f = 0; f < frame_table.size(); f++) begin
      for (int b = 0; b < fft16_pkg::n_points; b++) begin
        idx  = f * fft16_pkg::n_points + b;
        name = $sformatf("%s pass %0d bin %0d", frame_table[f].name, pass, b);
        check_value({name, " re"}, expected_re(frame_table[f], b), out_q[idx].re);
        check_value({name, " im"}, 0, out_q[idx].im);
        check_value({name, " last"}, int'(b == fft16_pkg::n_points - 1), int'(last_q[idx]));
      end
    end
  endtask

  // Source spends one credit per sample
  always @(posedge clk) begin
    if (rst_n && src_credits > 0 && stim_q.size() > 0) begin
      in_sample  <= stim_q[0].sample;
      in_inverse <= stim_q[0].inverse;
      in_valid   <= 1'b1;
      void'(stim_q.pop_front());
    end else begin
      in_valid <= 1'b0;
    end
  end

  // Sink keeps at most four grants open
  always @(posedge clk) begin
    if (!rst_n)                    out_credit <= 1'b0;
    else if (sink_outstanding < 4) out_credit <= !random_grants || (($random(seed) & 1) != 0);
    else                           out_credit <= 1'b0;
  end

  // Handshake signals are settled at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      src_credits      = fft16_pkg::in_credits;
      sent_count       = 0;
      returned_count   = 0;
      sink_outstanding = 0;
    end else begin
      if (in_valid) begin
        sent_count++;
        src_credits--;
      end
      if (in_credit) begin
        returned_count++;
        src_credits++;
        if (returned_count > sent_count) begin
          error_count++;
          $display("An input credit came back for a sample that was never sent");
        end
      end
      if (out_valid) begin
        if (sink_outstanding == 0) begin
          error_count++;
          $display("An output sample was sent without a credit from the sink");
        end
        out_q.push_back(out_sample);
        last_q.push_back(out_last);
        sink_outstanding--;
      end
      if (out_credit) sink_outstanding++;
    end
  end

  initial begin
    add_row("impulse_fwd", pat_impulse, 1600, 1'b0, -1, 100);
    add_row("impulse_inv", pat_impulse, 1600, 1'b1, -1, 100);
    add_row("dc_fwd", pat_dc, 100, 1'b0, 0, 100);
    add_row("tone_fwd", pat_tone, 100, 1'b0, 4, 100);
    add_row("tone_inv", pat_tone, 100, 1'b1, 12, 100);
    add_row("tone_fwd_after_inv", pat_tone, 100, 1'b0, 4, 100);
    add_row("alt_fwd", pat_alt, 100, 1'b0, 8, 100);
    add_row("alt_inv", pat_alt, 100, 1'b1, 8, 100);
    add_row("dc_inv", pat_dc, 100, 1'b1, 0, 100);

    wait_reset(ok);
    if (ok) begin
      @(negedge clk);
      check_value("reset out_valid", 0, int'(out_valid));
      check_value("reset in_credit", 0, int'(in_credit));
    end

    // Pass 0 grants every cycle, pass 1 grants at random
    for (int pass = 0; pass < 2 && ok; pass++) begin
      @(negedge clk);
      random_grants = (pass == 1);
      out_q.delete();
      last_q.delete();
      load_frames();
      wait_outputs(frame_table.size() * fft16_pkg::n_points, ok);
      if (ok) check_outputs(pass);
    end
    if (ok) wait_credits(ok);

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/fft16_pkg.sv
hw/sample_loader.sv
hw/radix4_dft.sv
hw/twiddle_rotator.sv
hw/corner_turn.sv
hw/sample_unloader.sv
hw/fft16_sequencer.sv
hw/fft16_top.sv
dv/tb_clock_gen.sv
dv/fft16_properties.sv
dv/fft16_tb.sv

//--- Bender.yml
package:
  name: fft16

sources:
  - hw/fft16_pkg.sv
  - hw/sample_loader.sv
  - hw/radix4_dft.sv
  - hw/twiddle_rotator.sv
  - hw/corner_turn.sv
  - hw/sample_unloader.sv
  - hw/fft16_sequencer.sv
  - hw/fft16_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/fft16_properties.sv
      - dv/fft16_tb.sv
